// ==== common/rx_pkg.sv ====
package rx_pkg;

	// signed width of one adc sample
	localparam int ADC_BITS = 14;

	// width of the decimator accumulators
	localparam int ACC_BITS = 24;

	// width of one output word, I or Q
	localparam int SAMP_BITS = 16;

	// width of the oscillator phase accumulator
	localparam int PHASE_BITS = 32;

	// bit positions in the one-hot op word
	// register writes
	localparam int OP_SET_RX_CHAN = 0;
	localparam int OP_SET_RX_FREQ = 1;
	localparam int OP_SET_WF_FREQ = 2;
	localparam int OP_SET_WF_DECIM = 3;
	// events
	localparam int OP_GET_RX_SRQ = 4;
	localparam int OP_GET_RX_SAMP = 5;
	localparam int OP_RX_FLIP_BUFS = 6;
	localparam int OP_WF_SAMPLER_RST = 7;
	localparam int OP_GET_WF_SAMP_I = 8;
	localparam int OP_GET_WF_SAMP_Q = 9;

	// one complex output sample, I in the upper half
	typedef struct packed {
		logic signed [SAMP_BITS-1:0] i;
		logic signed [SAMP_BITS-1:0] q;
	} iq_sample_t;

	// cpu command bus as seen by the receiver
	typedef struct packed {
		logic [31:0] tos;
		logic [15:0] op;
		logic wr_reg;
		logic wr_evt;
		logic rd_bit;
	} cmd_t;

	// one term of the square-wave mixer
	// the sample passes through or is negated, one bit wider so -2^13 survives
	function automatic logic signed [ADC_BITS:0] quad_term(
		input logic signed [ADC_BITS-1:0] x,
		input logic neg
	);
		logic signed [ADC_BITS:0] ext;
		ext = x;
		return neg ? -ext : ext;
	endfunction

endpackage

// ==== rx_chan/sample_buf.sv ====
module sample_buf #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 8
)(
	input logic cpu_clk,
	input logic rst_n,
	input logic push,
	input payload_t wdata,
	input logic flip,
	input logic pop,
	output payload_t rdata,
	output logic full_pulse
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t mem [2][DEPTH];
	// bank being written, the other one is read
	logic bank;
	logic [AW:0] wcount;
	logic [AW-1:0] rptr;
	logic full;
	logic do_push;

	assign full = (wcount == (AW+1)'(DEPTH));
	// a flip in the same cycle wins over the push
	assign do_push = push & ~full & ~flip;
	// pulse on the push that takes the last slot
	assign full_pulse = do_push & (wcount == (AW+1)'(DEPTH - 1));

	// head of the read bank
	assign rdata = mem[~bank][rptr];

	// both banks come up zeroed so an early read returns 0
	always_ff @(posedge cpu_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int b = 0; b < 2; b++)
				for (int k = 0; k < DEPTH; k++)
					mem[b][k] <= '0;
		end
		else if (do_push)
			mem[bank][wcount[AW-1:0]] <= wdata;
	end

	always_ff @(posedge cpu_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bank <= 1'b0;
			wcount <= '0;
			rptr <= '0;
		end
		else if (flip)
		begin
			// swap roles, fresh write bank, read from word 0
			bank <= ~bank;
			wcount <= '0;
			rptr <= '0;
		end
		else
		begin
			if (do_push)
				wcount <= wcount + 1'b1;
			// no empty check, an extra pop just wraps
			if (pop)
				rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
		end
	end

endmodule

// ==== rx_chan/rx_chan.sv ====
module rx_chan
	import rx_pkg::*;
#(
	parameter int BUF_DEPTH = 8,
	parameter int RX_DECIM = 4,
	parameter int RX_SHIFT = 2
)(
	input logic cpu_clk,
	input logic rst_n,
	input logic adc_valid,
	input logic signed [ADC_BITS-1:0] adc_data,
	input logic set_freq,
	input logic [31:0] freq,
	input logic flip,
	input logic rd_next,
	output logic srq,
	output logic [15:0] dout
);
	localparam int CNT_BITS = (RX_DECIM > 1) ? $clog2(RX_DECIM) : 1;

	logic [PHASE_BITS-1:0] freq_reg;
	logic [PHASE_BITS-1:0] phase;
	logic [1:0] quad;
	logic signed [ADC_BITS:0] mix_i;
	logic signed [ADC_BITS:0] mix_q;
	logic signed [ACC_BITS-1:0] acc_i;
	logic signed [ACC_BITS-1:0] acc_q;
	logic signed [ACC_BITS-1:0] sum_i;
	logic signed [ACC_BITS-1:0] sum_q;
	logic [CNT_BITS-1:0] cnt;
	logic last;
	logic push;
	iq_sample_t push_samp;
	iq_sample_t head;
	logic half;

	// quadrant from the phase before this sample's increment
	assign quad = phase[PHASE_BITS-1 -: 2];
	// I flips in quadrants 1 and 2, Q in 2 and 3
	assign mix_i = quad_term(adc_data, quad[1] ^ quad[0]);
	assign mix_q = quad_term(adc_data, quad[1]);

	assign sum_i = acc_i + ACC_BITS'(mix_i);
	assign sum_q = acc_q + ACC_BITS'(mix_q);
	assign last = (cnt == CNT_BITS'(RX_DECIM - 1));

	always_ff @(posedge cpu_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			freq_reg <= '0;
			phase <= '0;
			acc_i <= '0;
			acc_q <= '0;
			cnt <= '0;
			push <= 1'b0;
		end
		else if (set_freq)
		begin
			// new frequency restarts oscillator and decimator
			freq_reg <= freq;
			phase <= '0;
			acc_i <= '0;
			acc_q <= '0;
			cnt <= '0;
			push <= 1'b0;
		end
		else
		begin
			push <= 1'b0;
			if (adc_valid)
			begin
				phase <= phase + freq_reg;
				if (last)
				begin
					// full sum goes to push_samp, accumulator starts over
					acc_i <= '0;
					acc_q <= '0;
					cnt <= '0;
					push <= 1'b1;
				end
				else
				begin
					acc_i <= sum_i;
					acc_q <= sum_q;
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// scaled and truncated output sample, pushed on the next cycle
	always_ff @(posedge cpu_clk)
		if (adc_valid && last)
			push_samp <= '{i: SAMP_BITS'(sum_i >>> RX_SHIFT), q: SAMP_BITS'(sum_q >>> RX_SHIFT)};

	// fullness is decided inside the buffer
	sample_buf #(
		.payload_t(iq_sample_t),
		.DEPTH(BUF_DEPTH)
	) buf_i (
		.cpu_clk(cpu_clk),
		.rst_n(rst_n),
		.push(push),
		.wdata(push_samp),
		.flip(flip),
		.pop(rd_next & half),
		.rdata(head),
		.full_pulse(srq)
	);

	// word pointer low bit: 0 reads I, 1 reads Q and then moves on
	always_ff @(posedge cpu_clk or negedge rst_n)
	begin
		if (!rst_n)
			half <= 1'b0;
		else if (flip)
			half <= 1'b0;
		else if (rd_next)
			half <= ~half;
	end

	assign dout = half ? head.q : head.i;

endmodule

// ==== waterfall/waterfall.sv ====
module waterfall
	import rx_pkg::*;
#(
	parameter int WF_DEPTH = 8
)(
	input logic cpu_clk,
	input logic rst_n,
	input logic adc_valid,
	input logic signed [ADC_BITS-1:0] adc_data,
	input logic set_freq,
	input logic set_decim,
	input logic [31:0] cfg,
	input logic restart,
	input logic get_i,
	input logic get_q,
	output logic [15:0] dout
);
	logic [PHASE_BITS-1:0] freq_reg;
	logic [PHASE_BITS-1:0] phase;
	// decimation minus one, 0..255
	logic [7:0] decim_m1;
	logic [7:0] cnt;
	logic capturing;
	logic [1:0] quad;
	logic signed [ADC_BITS:0] mix_i;
	logic signed [ADC_BITS:0] mix_q;
	logic signed [ACC_BITS-1:0] acc_i;
	logic signed [ACC_BITS-1:0] acc_q;
	logic signed [ACC_BITS-1:0] sum_i;
	logic signed [ACC_BITS-1:0] sum_q;
	logic last;
	logic push;
	iq_sample_t push_samp;
	iq_sample_t head;
	logic full_pulse;
	logic frame_done;

	// same quadrant mixer as the rx channels
	assign quad = phase[PHASE_BITS-1 -: 2];
	assign mix_i = quad_term(adc_data, quad[1] ^ quad[0]);
	assign mix_q = quad_term(adc_data, quad[1]);
	assign sum_i = acc_i + ACC_BITS'(mix_i);
	assign sum_q = acc_q + ACC_BITS'(mix_q);
	assign last = (cnt == decim_m1);

	always_ff @(posedge cpu_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			freq_reg <= '0;
			phase <= '0;
			decim_m1 <= '0;
			cnt <= '0;
			acc_i <= '0;
			acc_q <= '0;
			capturing <= 1'b0;
			push <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			push <= 1'b0;
			frame_done <= full_pulse;
			if (set_decim)
				decim_m1 <= cfg[7:0];
			if (set_freq || restart)
			begin
				phase <= '0;
				acc_i <= '0;
				acc_q <= '0;
				cnt <= '0;
			end
			else if (adc_valid)
			begin
				// oscillator free-runs, the decimator only while capturing
				phase <= phase + freq_reg;
				if (capturing && last)
				begin
					acc_i <= '0;
					acc_q <= '0;
					cnt <= '0;
					push <= 1'b1;
				end
				else if (capturing)
				begin
					acc_i <= sum_i;
					acc_q <= sum_q;
					cnt <= cnt + 1'b1;
				end
			end
			if (set_freq)
				freq_reg <= cfg;
			// single shot, stop once the frame is in
			if (restart)
				capturing <= 1'b1;
			else if (full_pulse)
				capturing <= 1'b0;
		end
	end

	// shift of 0, low 16 bits of each sum
	always_ff @(posedge cpu_clk)
		if (adc_valid && last)
			push_samp <= '{i: sum_i[SAMP_BITS-1:0], q: sum_q[SAMP_BITS-1:0]};

	// the completed frame is flipped over to the read side
	sample_buf #(
		.payload_t(iq_sample_t),
		.DEPTH(WF_DEPTH)
	) buf_i (
		.cpu_clk(cpu_clk),
		.rst_n(rst_n),
		.push(push),
		.wdata(push_samp),
		.flip(frame_done),
		.pop(get_q),
		.rdata(head),
		.full_pulse(full_pulse)
	);

	// I on get_i, otherwise Q of the head
	assign dout = get_i ? head.i : head.q;

endmodule

// ==== hdl/srq_serializer.sv ====
module srq_serializer #(
	parameter int RX_CHANS = 4
)(
	input logic cpu_clk,
	input logic rst_n,
	input logic [RX_CHANS-1:0] srq_vec,
	input logic load,
	input logic sel_clear,
	input logic rd_bit,
	output logic ser
);
	logic [RX_CHANS-1:0] noted;
	logic [RX_CHANS-1:0] shift;
	logic ser_sel;

	always_ff @(posedge cpu_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			noted <= '0;
			shift <= '0;
			ser_sel <= 1'b0;
		end
		else
		begin
			// requests pile up until software collects them
			// on collection only this cycle's requests are kept
			if (load)
				noted <= srq_vec;
			else
				noted <= noted | srq_vec;

			// snapshot of what was noted before this cycle
			if (load)
				shift <= noted;
			else if (rd_bit && ser_sel)
				shift <= shift << 1;

			// bit reads belong to the serializer until another event
			if (load)
				ser_sel <= 1'b1;
			else if (sel_clear)
				ser_sel <= 1'b0;
		end
	end

	// highest channel goes out first
	assign ser = shift[RX_CHANS-1];

endmodule

// ==== hdl/receiver.sv ====
module receiver
	import rx_pkg::*;
#(
	parameter int RX_CHANS = 4,
	parameter int BUF_DEPTH = 8,
	parameter int RX_DECIM = 4,
	parameter int RX_SHIFT = 2
)(
	input logic cpu_clk,
	input logic rst_n,
	input logic adc_valid,
	input logic signed [ADC_BITS-1:0] adc_data,
	input logic [31:0] tos,
	input logic [15:0] op,
	input logic wr_reg,
	input logic wr_evt,
	input logic rd_bit,
	output logic ser,
	output logic rx_rd,
	output logic [15:0] rx_dout,
	output logic wf_rd,
	output logic [15:0] wf_dout
);
	localparam int CH_BITS = (RX_CHANS > 1) ? $clog2(RX_CHANS) : 1;

	cmd_t cmd;
	logic set_rx_chan;
	logic set_rx_freq;
	logic set_wf_freq;
	logic set_wf_decim;
	logic get_rx_srq;
	logic get_rx_samp;
	logic flip_bufs;
	logic rst_wf_sampler;
	logic get_wf_samp_i;
	logic get_wf_samp_q;
	logic [31:0] frozen_tos;
	logic set_rx_freq_d;
	logic set_wf_freq_d;
	logic set_wf_decim_d;
	logic [CH_BITS-1:0] rx_channel;
	logic [RX_CHANS-1:0] chan_srq;
	logic [SAMP_BITS-1:0] chan_dout [RX_CHANS];

	// gather the command bus into one struct
	assign cmd = '{tos: tos, op: op, wr_reg: wr_reg, wr_evt: wr_evt, rd_bit: rd_bit};

	// register writes
	assign set_rx_chan = cmd.wr_reg & cmd.op[OP_SET_RX_CHAN];
	assign set_rx_freq = cmd.wr_reg & cmd.op[OP_SET_RX_FREQ];
	assign set_wf_freq = cmd.wr_reg & cmd.op[OP_SET_WF_FREQ];
	assign set_wf_decim = cmd.wr_reg & cmd.op[OP_SET_WF_DECIM];

	// events
	assign get_rx_srq = cmd.wr_evt & cmd.op[OP_GET_RX_SRQ];
	assign get_rx_samp = cmd.wr_evt & cmd.op[OP_GET_RX_SAMP];
	assign flip_bufs = cmd.wr_evt & cmd.op[OP_RX_FLIP_BUFS];
	assign rst_wf_sampler = cmd.wr_evt & cmd.op[OP_WF_SAMPLER_RST];
	assign get_wf_samp_i = cmd.wr_evt & cmd.op[OP_GET_WF_SAMP_I];
	assign get_wf_samp_q = cmd.wr_evt & cmd.op[OP_GET_WF_SAMP_Q];

	// tos is held on every register write
	always_ff @(posedge cpu_clk)
		if (cmd.wr_reg)
			frozen_tos <= cmd.tos;

	// set strobes line up with frozen_tos one cycle later
	always_ff @(posedge cpu_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			set_rx_freq_d <= 1'b0;
			set_wf_freq_d <= 1'b0;
			set_wf_decim_d <= 1'b0;
			rx_channel <= '0;
		end
		else
		begin
			set_rx_freq_d <= set_rx_freq;
			set_wf_freq_d <= set_wf_freq;
			set_wf_decim_d <= set_wf_decim;
			// channel number comes straight from tos, not the frozen copy
			if (set_rx_chan)
				rx_channel <= cmd.tos[CH_BITS-1:0];
		end
	end

	// one receive channel per index
	// freq and read strobes go only to the selected channel
	for (genvar n = 0; n < RX_CHANS; n++)
	begin : g_chan
		rx_chan #(
			.BUF_DEPTH(BUF_DEPTH),
			.RX_DECIM(RX_DECIM),
			.RX_SHIFT(RX_SHIFT)
		) rx_chan_i (
			.cpu_clk(cpu_clk),
			.rst_n(rst_n),
			.adc_valid(adc_valid),
			.adc_data(adc_data),
			.set_freq(set_rx_freq_d && (rx_channel == CH_BITS'(n))),
			.freq(frozen_tos),
			.flip(flip_bufs),
			.rd_next(get_rx_samp && (rx_channel == CH_BITS'(n))),
			.srq(chan_srq[n]),
			.dout(chan_dout[n])
		);
	end

	// read word of the selected channel
	assign rx_dout = chan_dout[rx_channel];
	assign rx_rd = get_rx_samp;

	// service requests out to the cpu one bit at a time
	srq_serializer #(
		.RX_CHANS(RX_CHANS)
	) srq_i (
		.cpu_clk(cpu_clk),
		.rst_n(rst_n),
		.srq_vec(chan_srq),
		.load(get_rx_srq),
		.sel_clear(cmd.wr_evt & ~cmd.op[OP_GET_RX_SRQ]),
		.rd_bit(cmd.rd_bit),
		.ser(ser)
	);

	waterfall #(
		.WF_DEPTH(BUF_DEPTH)
	) wf_i (
		.cpu_clk(cpu_clk),
		.rst_n(rst_n),
		.adc_valid(adc_valid),
		.adc_data(adc_data),
		.set_freq(set_wf_freq_d),
		.set_decim(set_wf_decim_d),
		.cfg(frozen_tos),
		.restart(rst_wf_sampler),
		.get_i(get_wf_samp_i),
		.get_q(get_wf_samp_q),
		.dout(wf_dout)
	);

	assign wf_rd = get_wf_samp_i | get_wf_samp_q;

endmodule

// ==== bench/receiver_chk.sv ====
module receiver_chk
	import rx_pkg::*;
#(
	parameter int RX_CHANS = 4
)(
	input logic cpu_clk,
	input logic rst_n,
	input logic [31:0] tos,
	input logic [15:0] op,
	input logic wr_reg,
	input logic wr_evt,
	input logic ser,
	input logic rx_rd,
	input logic wf_rd
);
	// one op bit per strobe
	a_onehot_op: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		(wr_reg || wr_evt) |-> $onehot0(op))
		else $error("more than one op bit set under a strobe");

	// rx_rd follows the get_rx_samp event exactly
	a_rx_rd: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		rx_rd == (wr_evt && op[OP_GET_RX_SAMP]))
		else $error("rx_rd does not match the get_rx_samp event");

	// outputs quiet in reset
	a_reset_quiet: assert property (@(posedge cpu_clk)
		!rst_n |-> (!ser && !rx_rd && !wf_rd))
		else $error("outputs active during reset");

	// channel number written by software stays inside the channel range
	a_chan_range: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		(wr_reg && op[OP_SET_RX_CHAN]) |-> (tos < RX_CHANS))
		else $error("channel index out of range");

endmodule

// ==== bench/rx_monitor.sv ====
module rx_monitor
	import rx_pkg::*;
#(
	parameter int RX_CHANS = 4,
	parameter int BUF_DEPTH = 8,
	parameter int RX_DECIM = 4,
	parameter int RX_SHIFT = 2
)(
	input logic cpu_clk,
	input logic rst_n,
	input logic adc_valid,
	input logic signed [ADC_BITS-1:0] adc_data,
	input logic [31:0] tos,
	input logic [15:0] op,
	input logic wr_reg,
	input logic wr_evt,
	input logic rd_bit,
	input logic ser,
	input logic rx_rd,
	input logic [15:0] rx_dout,
	input logic wf_rd,
	input logic [15:0] wf_dout,
	output int errors,
	output logic wf_ready
);
	// rx channel model
	logic [31:0] freq [RX_CHANS];
	logic [31:0] phase [RX_CHANS];
	int acc_i [RX_CHANS];
	int acc_q [RX_CHANS];
	int cnt [RX_CHANS];
	bit push_p [RX_CHANS];
	logic [15:0] push_i [RX_CHANS];
	logic [15:0] push_q [RX_CHANS];
	logic [15:0] mem_i [RX_CHANS][2][BUF_DEPTH];
	logic [15:0] mem_q [RX_CHANS][2][BUF_DEPTH];
	bit bank [RX_CHANS];
	int wcount [RX_CHANS];
	int rptr [RX_CHANS];
	bit half [RX_CHANS];
	// command decode and serializer model
	int chan;
	logic [31:0] frozen;
	bit set_rx_d;
	bit set_wf_f_d;
	bit set_wf_d_d;
	logic [RX_CHANS-1:0] noted;
	logic [RX_CHANS-1:0] shift;
	bit sel;
	// waterfall model
	logic [31:0] w_freq;
	logic [31:0] w_phase;
	int w_dm1;
	int w_acc_i;
	int w_acc_q;
	int w_cnt;
	bit w_cap;
	bit w_push;
	bit w_fd;
	logic [15:0] w_pi;
	logic [15:0] w_pq;
	logic [15:0] w_mem_i [2][BUF_DEPTH];
	logic [15:0] w_mem_q [2][BUF_DEPTH];
	bit w_bank;
	int w_wc;
	int w_rp;

	// square-wave mixer term
	function automatic int mix(input int x, input bit neg);
		return neg ? -x : x;
	endfunction

	// inputs change just after the rising edge, so the falling edge sees stable values
	always @(negedge cpu_clk or negedge rst_n)
	begin : model
		logic [RX_CHANS-1:0] srqv;
		logic [15:0] exp_w;
		bit flip;
		bit dopush;
		bit pnext;
		bit restart;
		bit fp;
		bit rx_rd_exp;
		bit wf_rd_exp;
		int x;
		int si;
		int sq;
		logic [1:0] qd;
		if (!rst_n)
		begin
			chan = 0;
			frozen = '0;
			set_rx_d = 0;
			set_wf_f_d = 0;
			set_wf_d_d = 0;
			noted = '0;
			shift = '0;
			sel = 0;
			for (int n = 0; n < RX_CHANS; n++)
			begin
				freq[n] = '0;
				phase[n] = '0;
				acc_i[n] = 0;
				acc_q[n] = 0;
				cnt[n] = 0;
				push_p[n] = 0;
				bank[n] = 0;
				wcount[n] = 0;
				rptr[n] = 0;
				half[n] = 0;
				for (int k = 0; k < BUF_DEPTH; k++)
				begin
					mem_i[n][0][k] = '0;
					mem_i[n][1][k] = '0;
					mem_q[n][0][k] = '0;
					mem_q[n][1][k] = '0;
				end
			end
			w_freq = '0;
			w_phase = '0;
			w_dm1 = 0;
			w_acc_i = 0;
			w_acc_q = 0;
			w_cnt = 0;
			w_cap = 0;
			w_push = 0;
			w_fd = 0;
			w_bank = 0;
			w_wc = 0;
			w_rp = 0;
			wf_ready = 0;
			for (int k = 0; k < BUF_DEPTH; k++)
			begin
				w_mem_i[0][k] = '0;
				w_mem_i[1][k] = '0;
				w_mem_q[0][k] = '0;
				w_mem_q[1][k] = '0;
			end
		end
		else
		begin
			x = int'(adc_data);
			srqv = '0;
			// read strobes come from the get events on the bus
			rx_rd_exp = wr_evt && op[OP_GET_RX_SAMP];
			wf_rd_exp = wr_evt && (op[OP_GET_WF_SAMP_I] || op[OP_GET_WF_SAMP_Q]);
			// compare outputs against the state before this edge
			if (rx_rd !== rx_rd_exp)
			begin
				$display("Mismatch at %0t: rx_rd got %b expected %b", $time, rx_rd, rx_rd_exp);
				errors++;
			end
			if (rx_rd_exp)
			begin
				exp_w = half[chan] ? mem_q[chan][~bank[chan]][rptr[chan]]
					: mem_i[chan][~bank[chan]][rptr[chan]];
				if (rx_dout !== exp_w)
				begin
					$display("Mismatch at %0t: rx ch %0d word got %h expected %h",
						$time, chan, rx_dout, exp_w);
					errors++;
				end
			end
			if (wf_rd !== wf_rd_exp)
			begin
				$display("Mismatch at %0t: wf_rd got %b expected %b", $time, wf_rd, wf_rd_exp);
				errors++;
			end
			if (wf_rd_exp)
			begin
				exp_w = op[OP_GET_WF_SAMP_I] ? w_mem_i[~w_bank][w_rp] : w_mem_q[~w_bank][w_rp];
				if (wf_dout !== exp_w)
				begin
					$display("Mismatch at %0t: wf word got %h expected %h", $time, wf_dout, exp_w);
					errors++;
				end
			end
			// ser is the shift register msb in every cycle
			if (ser !== shift[RX_CHANS-1])
			begin
				$display("Mismatch at %0t: srq bit got %b expected %b",
					$time, ser, shift[RX_CHANS-1]);
				errors++;
			end

			flip = wr_evt && op[OP_RX_FLIP_BUFS];
			for (int n = 0; n < RX_CHANS; n++)
			begin
				// a flip in the same cycle drops the push
				dopush = push_p[n] && wcount[n] < BUF_DEPTH && !flip;
				if (dopush)
				begin
					mem_i[n][bank[n]][wcount[n]] = push_i[n];
					mem_q[n][bank[n]][wcount[n]] = push_q[n];
					if (wcount[n] == BUF_DEPTH - 1)
						srqv[n] = 1'b1;
				end
				pnext = 0;
				if (set_rx_d && chan == n)
				begin
					freq[n] = frozen;
					phase[n] = '0;
					acc_i[n] = 0;
					acc_q[n] = 0;
					cnt[n] = 0;
				end
				else if (adc_valid)
				begin
					qd = phase[n][31:30];
					si = acc_i[n] + mix(x, qd == 2'd1 || qd == 2'd2);
					sq = acc_q[n] + mix(x, qd[1]);
					phase[n] = phase[n] + freq[n];
					if (cnt[n] == RX_DECIM - 1)
					begin
						push_i[n] = 16'(si >>> RX_SHIFT);
						push_q[n] = 16'(sq >>> RX_SHIFT);
						acc_i[n] = 0;
						acc_q[n] = 0;
						cnt[n] = 0;
						pnext = 1;
					end
					else
					begin
						acc_i[n] = si;
						acc_q[n] = sq;
						cnt[n]++;
					end
				end
				push_p[n] = pnext;
				if (flip)
				begin
					bank[n] = ~bank[n];
					wcount[n] = 0;
					rptr[n] = 0;
					half[n] = 0;
				end
				else
				begin
					if (dopush)
						wcount[n]++;
					if (wr_evt && op[OP_GET_RX_SAMP] && chan == n)
					begin
						if (half[n])
							rptr[n] = (rptr[n] + 1) % BUF_DEPTH;
						half[n] = ~half[n];
					end
				end
			end

			// serializer
			if (wr_evt && op[OP_GET_RX_SRQ])
			begin
				shift = noted;
				noted = srqv;
				sel = 1;
			end
			else
			begin
				if (rd_bit && sel)
					shift = shift << 1;
				noted = noted | srqv;
				if (wr_evt)
					sel = 0;
			end

			// waterfall, frame flip is one cycle after the filling push
			restart = wr_evt && op[OP_WF_SAMPLER_RST];
			dopush = w_push && w_wc < BUF_DEPTH && !w_fd;
			fp = dopush && w_wc == BUF_DEPTH - 1;
			if (dopush)
			begin
				w_mem_i[w_bank][w_wc] = w_pi;
				w_mem_q[w_bank][w_wc] = w_pq;
			end
			pnext = 0;
			if (set_wf_f_d || restart)
			begin
				w_phase = '0;
				w_acc_i = 0;
				w_acc_q = 0;
				w_cnt = 0;
			end
			else if (adc_valid)
			begin
				qd = w_phase[31:30];
				si = w_acc_i + mix(x, qd == 2'd1 || qd == 2'd2);
				sq = w_acc_q + mix(x, qd[1]);
				w_phase = w_phase + w_freq;
				if (w_cap && w_cnt == w_dm1)
				begin
					w_pi = 16'(si);
					w_pq = 16'(sq);
					w_acc_i = 0;
					w_acc_q = 0;
					w_cnt = 0;
					pnext = 1;
				end
				else if (w_cap)
				begin
					w_acc_i = si;
					w_acc_q = sq;
					w_cnt++;
				end
			end
			w_push = pnext;
			// new decimation counts from the next sample on
			if (set_wf_d_d)
				w_dm1 = int'(frozen[7:0]);
			if (set_wf_f_d)
				w_freq = frozen;
			if (restart)
				w_cap = 1;
			else if (fp)
				w_cap = 0;
			if (w_fd)
			begin
				w_bank = ~w_bank;
				w_wc = 0;
				w_rp = 0;
				wf_ready = 1;
			end
			else
			begin
				if (dopush)
					w_wc++;
				if (wr_evt && op[OP_GET_WF_SAMP_Q])
					w_rp = (w_rp + 1) % BUF_DEPTH;
			end
			w_fd = fp;
			if (restart)
				wf_ready = 0;

			// registers of the command decode
			set_rx_d = wr_reg && op[OP_SET_RX_FREQ];
			set_wf_f_d = wr_reg && op[OP_SET_WF_FREQ];
			set_wf_d_d = wr_reg && op[OP_SET_WF_DECIM];
			if (wr_reg)
				frozen = tos;
			if (wr_reg && op[OP_SET_RX_CHAN])
				chan = int'(tos) % RX_CHANS;
		end
	end

	initial
		errors = 0;

endmodule

// ==== bench/tb_receiver.sv ====
module tb_receiver;
	import rx_pkg::*;

	localparam int RX_CHANS = 4;
	localparam int BUF_DEPTH = 8;
	localparam int RX_DECIM = 4;
	localparam int RX_SHIFT = 2;

	// stimulus commands
	localparam int C_SET_CHAN = 0;
	localparam int C_SET_FREQ = 1;
	localparam int C_SET_WF_DECIM = 2;
	localparam int C_SET_WF_FREQ = 3;
	localparam int C_WF_RESTART = 4;
	localparam int C_FEED = 5;
	localparam int C_FLIP = 6;
	localparam int C_READ = 7;
	localparam int C_READ_SRQ = 8;
	localparam int C_WF_WAIT = 9;
	localparam int C_READ_WF = 10;
	localparam int ROWS = 27;

	typedef struct packed {
		logic [7:0] cmd;
		logic [31:0] arg;
	} row_t;

	logic cpu_clk;
	logic rst_n;
	logic adc_valid;
	logic signed [ADC_BITS-1:0] adc_data;
	logic [31:0] tos;
	logic [15:0] op;
	logic wr_reg;
	logic wr_evt;
	logic rd_bit;
	logic ser;
	logic rx_rd;
	logic [15:0] rx_dout;
	logic wf_rd;
	logic [15:0] wf_dout;
	int mon_errors;
	logic wf_ready;
	int timeouts;
	row_t table_rows [ROWS];

	receiver #(
		.RX_CHANS(RX_CHANS),
		.BUF_DEPTH(BUF_DEPTH),
		.RX_DECIM(RX_DECIM),
		.RX_SHIFT(RX_SHIFT)
	) dut_i (.*);

	rx_monitor #(
		.RX_CHANS(RX_CHANS),
		.BUF_DEPTH(BUF_DEPTH),
		.RX_DECIM(RX_DECIM),
		.RX_SHIFT(RX_SHIFT)
	) mon_i (.*, .errors(mon_errors), .wf_ready(wf_ready));

	bind receiver receiver_chk #(
		.RX_CHANS(RX_CHANS)
	) chk_i (
		.cpu_clk(cpu_clk),
		.rst_n(rst_n),
		.tos(tos),
		.op(op),
		.wr_reg(wr_reg),
		.wr_evt(wr_evt),
		.ser(ser),
		.rx_rd(rx_rd),
		.wf_rd(wf_rd)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever
			#2 cpu_clk = ~cpu_clk;
	end

	// inputs move 1 time unit after the rising edge
	task automatic tick();
		@(posedge cpu_clk);
		#1;
	endtask

	task automatic write_reg(input int bit_pos, input logic [31:0] value);
		wr_reg = 1'b1;
		op = 16'(1 << bit_pos);
		tos = value;
		tick();
		wr_reg = 1'b0;
		op = '0;
		// delayed set strobe lands on the next edge
		tick();
		tick();
	endtask

	task automatic send_event(input int bit_pos);
		wr_evt = 1'b1;
		op = 16'(1 << bit_pos);
		tick();
		wr_evt = 1'b0;
		op = '0;
	endtask

	task automatic feed_samples(input int count);
		for (int k = 0; k < count; k++)
		begin
			adc_valid = 1'b1;
			adc_data = ADC_BITS'($urandom);
			tick();
		end
		adc_valid = 1'b0;
		tick();
		tick();
	endtask

	task automatic apply_row(input row_t r);
		case (int'(r.cmd))
			C_SET_CHAN: write_reg(OP_SET_RX_CHAN, r.arg);
			C_SET_FREQ: write_reg(OP_SET_RX_FREQ, r.arg);
			C_SET_WF_DECIM: write_reg(OP_SET_WF_DECIM, r.arg);
			C_SET_WF_FREQ: write_reg(OP_SET_WF_FREQ, r.arg);
			C_WF_RESTART: send_event(OP_WF_SAMPLER_RST);
			C_FEED: feed_samples(int'(r.arg));
			C_FLIP: send_event(OP_RX_FLIP_BUFS);
			C_READ:
				for (int k = 0; k < int'(r.arg); k++)
					send_event(OP_GET_RX_SAMP);
			C_READ_SRQ:
			begin
				send_event(OP_GET_RX_SRQ);
				rd_bit = 1'b1;
				repeat (RX_CHANS)
					tick();
				rd_bit = 1'b0;
			end
			C_WF_WAIT:
			begin : wf_wait
				int n;
				n = 0;
				while (!wf_ready && n < int'(r.arg))
				begin
					tick();
					n++;
				end
				if (!wf_ready)
				begin
					$display("Timeout at %0t: waterfall frame never completed", $time);
					timeouts++;
				end
			end
			C_READ_WF:
				for (int k = 0; k < int'(r.arg); k++)
				begin
					send_event(OP_GET_WF_SAMP_I);
					send_event(OP_GET_WF_SAMP_Q);
				end
			default: $display("Unknown stimulus command %0d", r.cmd);
		endcase
		tick();
	endtask

	initial
	begin
		adc_valid = 1'b0;
		adc_data = '0;
		tos = '0;
		op = '0;
		wr_reg = 1'b0;
		wr_evt = 1'b0;
		rd_bit = 1'b0;
		rst_n = 1'b0;
		timeouts = 0;
		void'($urandom(87));
		table_rows = '{
			// reset bank reads as zero
			'{8'(C_READ), 32'd2},
			// zero frequency on channel 0
			'{8'(C_SET_CHAN), 32'd0},
			'{8'(C_SET_FREQ), 32'd0},
			'{8'(C_FEED), 32'(RX_DECIM * BUF_DEPTH)},
			'{8'(C_FLIP), 32'd0},
			'{8'(C_READ), 32'(2 * BUF_DEPTH)},
			// distinct frequencies on the other channels
			'{8'(C_SET_CHAN), 32'd1},
			'{8'(C_SET_FREQ), 32'h1000_0000},
			'{8'(C_SET_CHAN), 32'd2},
			'{8'(C_SET_FREQ), 32'h4000_0000},
			'{8'(C_SET_CHAN), 32'd3},
			'{8'(C_SET_FREQ), 32'ha000_0000},
			'{8'(C_FEED), 32'(RX_DECIM * BUF_DEPTH)},
			// all ones, then all zeros
			'{8'(C_READ_SRQ), 32'd0},
			'{8'(C_READ_SRQ), 32'd0},
			'{8'(C_FLIP), 32'd0},
			'{8'(C_READ), 32'd6},
			'{8'(C_SET_CHAN), 32'd1},
			'{8'(C_READ), 32'd4},
			'{8'(C_SET_CHAN), 32'd2},
			'{8'(C_READ), 32'd4},
			'{8'(C_SET_CHAN), 32'd3},
			'{8'(C_READ), 32'd4},
			// waterfall with decimation 6
			'{8'(C_SET_WF_DECIM), 32'd5},
			'{8'(C_SET_WF_FREQ), 32'h3000_0000},
			'{8'(C_WF_RESTART), 32'd0},
			'{8'(C_FEED), 32'd56}
		};
		repeat (10)
			@(posedge cpu_clk);
		#1;
		rst_n = 1'b1;
		tick();
		for (int r = 0; r < ROWS; r++)
			apply_row(table_rows[r]);
		apply_row('{8'(C_WF_WAIT), 32'd1000});
		apply_row('{8'(C_READ_WF), 32'(BUF_DEPTH)});
		tick();
		$display("closing: %0d mismatches, %0d timeouts", mon_errors, timeouts);
		if (mon_errors == 0 && timeouts == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== sources.f ====
common/rx_pkg.sv
rx_chan/sample_buf.sv
rx_chan/rx_chan.sv
waterfall/waterfall.sv
hdl/srq_serializer.sv
hdl/receiver.sv
bench/receiver_chk.sv
bench/rx_monitor.sv
bench/tb_receiver.sv
